// ==== axi_cdc_mem.f ====
hdl/axi_pkg.sv
hdl/cdc_pkg.sv
hdl/cdc_async_fifo.sv
hdl/axi_async_bridge.sv
hdl/axi_mem_slave.sv
hdl/axi_cdc_mem_top.sv
sim/tb_clock_gen.sv
sim/axi_cdc_mem_tb.sv

// ==== Bender.yml ====
package:
  name: axi_cdc_mem

sources:
  - hdl/axi_pkg.sv
  - hdl/cdc_pkg.sv
  - hdl/cdc_async_fifo.sv
  - hdl/axi_async_bridge.sv
  - hdl/axi_mem_slave.sv
  - hdl/axi_cdc_mem_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/axi_cdc_mem_tb.sv

// ==== sim/axi_cdc_mem_tb.sv ====
`timescale 1ns/100ps

module axi_cdc_mem_tb import axi_pkg::*; ();

  localparam real W_PERIOD   = 100.0;
  localparam real R_PERIOD   = 70.0;   // unrelated to w_clk, so the domains drift.
  localparam int  SEED       = 48029;
  localparam int  PLAN_BEATS = 64 + 2 + 12 * 32 + 16 + 10 * 32 + 16;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
    axi_data_t data;
    logic      last;
  } r_beat_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_rsp_t;

  logic       w_clk, r_clk, w_reset, r_reset;
  axi_addr_t  w_awaddr, w_araddr;
  axi_burst_t w_awburst, w_arburst;
  axi_id_t    w_awid, w_arid, w_bid, w_rid;
  axi_len_t   w_awlen, w_arlen;
  axi_size_t  w_awsize, w_arsize;
  logic       w_awvalid, w_arvalid, w_awready, w_arready;
  axi_data_t  w_wdata, w_rdata;
  axi_strb_t  w_wstrb;
  logic       w_wlast, w_wvalid, w_wready;
  axi_resp_t  w_bresp, w_rresp;
  logic       w_bvalid, w_rvalid, w_rlast, w_bready, w_rready;

  axi_data_t  ref_mem [MEM_WORDS];   // reference copy of the memory.
  b_rsp_t     b_q [$];
  r_beat_t    r_q [$];
  b_rsp_t     b_head;
  r_beat_t    r_head;
  logic       b_any, r_any, b_pop, r_pop;
  logic       stall_on, seen_request, idle_armed, full_strb;
  int         b_low, r_low;
  int         errors;

  axi_addr_t  addr;
  axi_len_t   len;
  axi_id_t    id;

  tb_clock_gen #(.period(W_PERIOD)) w_clk_gen (.clk(w_clk));
  tb_clock_gen #(.period(R_PERIOD)) r_clk_gen (.clk(r_clk));

  axi_cdc_mem_top dut0 (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // master tasks
  task automatic write_burst(input axi_addr_t a, input axi_burst_t burst,
                             input axi_len_t n, input axi_id_t tid);
    axi_data_t data;
    axi_strb_t strb;
    int        idx;
    logic      accepted;
    idx = int'((a / 8) % MEM_WORDS);
    b_q.push_back(b_rsp_t'{tid, (burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY});
    @(negedge w_clk);
    w_awaddr     = a;
    w_awburst    = burst;
    w_awid       = tid;
    w_awlen      = n;
    w_awsize     = 3'd3;
    w_awvalid    = 1'b1;
    seen_request = 1'b1;
    do begin
      accepted = w_awready;
      @(negedge w_clk);
    end while (!accepted);
    w_awvalid = 1'b0;
    for (int beat = 0; beat <= n; beat++) begin
      data = {$urandom, $urandom};
      strb = full_strb ? '1 : axi_strb_t'($urandom);
      if (burst != BURST_WRAP) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];   // bytewise merge.
        end
      end
      if (burst == BURST_INCR) idx = (idx + 1) % MEM_WORDS;
      w_wdata  = data;
      w_wstrb  = strb;
      w_wlast  = (beat == n);
      w_wvalid = 1'b1;
      do begin
        accepted = w_wready;
        @(negedge w_clk);
      end while (!accepted);
    end
    w_wvalid = 1'b0;
    w_wlast  = 1'b0;
    while (b_q.size() != 0) @(negedge w_clk);
  endtask

  task automatic read_burst(input axi_addr_t a, input axi_burst_t burst,
                            input axi_len_t n, input axi_id_t tid);
    r_beat_t exp;
    int      idx;
    logic    accepted;
    idx = int'((a / 8) % MEM_WORDS);
    for (int beat = 0; beat <= n; beat++) begin
      exp.id   = tid;
      exp.resp = (burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
      exp.data = (burst == BURST_WRAP) ? '0 : ref_mem[idx];
      exp.last = (beat == n);
      r_q.push_back(exp);
      if (burst == BURST_INCR) idx = (idx + 1) % MEM_WORDS;
    end
    @(negedge w_clk);
    w_araddr     = a;
    w_arburst    = burst;
    w_arid       = tid;
    w_arlen      = n;
    w_arsize     = 3'd3;
    w_arvalid    = 1'b1;
    seen_request = 1'b1;
    do begin
      accepted = w_arready;
      @(negedge w_clk);
    end while (!accepted);
    w_arvalid = 1'b0;
    while (r_q.size() != 0) @(negedge w_clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response bookkeeping and ready pattern
  always @(negedge w_clk) begin
    if (b_pop) b_q.delete(0);   // handshake at the last rising edge.
    if (r_pop) r_q.delete(0);
    b_any = (b_q.size() != 0);
    r_any = (r_q.size() != 0);
    if (b_any) b_head = b_q[0];
    if (r_any) r_head = r_q[0];
    if (b_low > 0) b_low = b_low - 1;
    else if (stall_on && $urandom % 8 == 0) b_low = $urandom % 20 + 1;
    if (r_low > 0) r_low = r_low - 1;
    else if (stall_on && $urandom % 8 == 0) r_low = $urandom % 20 + 1;
    w_bready = (b_low == 0);
    w_rready = (r_low == 0);
    b_pop    = w_bvalid && w_bready;
    r_pop    = w_rvalid && w_rready;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  assert property (@(posedge w_clk) idle_armed && !seen_request |-> !w_bvalid && !w_rvalid)
    else begin
      errors = errors + 1;
      $display("Error at %0t: response valid before any request", $time);
    end

  assert property (@(posedge w_clk)
      w_bvalid && w_bready |-> b_any && w_bid == b_head.id && w_bresp == b_head.resp)
    else begin
      errors = errors + 1;
      $display("Error at %0t: B id %0d resp %0d, expected id %0d resp %0d (pending %0b)",
               $time, w_bid, w_bresp, b_head.id, b_head.resp, b_any);
    end

  assert property (@(posedge w_clk)
      w_rvalid && w_rready |-> r_any && w_rid == r_head.id && w_rresp == r_head.resp
                               && w_rdata == r_head.data && w_rlast == r_head.last)
    else begin
      errors = errors + 1;
      $display("Error at %0t: R beat data %h last %0b, expected %h last %0b (pending %0b)",
               $time, w_rdata, w_rlast, r_head.data, r_head.last, r_any);
    end

  assert property (@(posedge w_clk) disable iff (w_reset)
      w_rvalid && !w_rready |=> w_rvalid && $stable(w_rdata) && $stable(w_rid)
                                && $stable(w_rresp) && $stable(w_rlast))
    else begin
      errors = errors + 1;
      $display("Error at %0t: R payload changed while stalled", $time);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  initial begin
    #(PLAN_BEATS * 40 * W_PERIOD);
    $display("Timeout: the responses did not all arrive within the time budget of the run.");
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    {w_reset, r_reset} = 2'b11;
    {w_awvalid, w_wvalid, w_arvalid, w_wlast} = '0;
    {w_awaddr, w_awburst, w_awid, w_awlen, w_awsize} = '0;
    {w_araddr, w_arburst, w_arid, w_arlen, w_arsize} = '0;
    {w_wdata, w_wstrb} = '0;
    {w_bready, w_rready} = 2'b11;
    {b_pop, r_pop, b_any, r_any} = '0;
    {stall_on, seen_request, idle_armed, full_strb} = '0;
    {b_low, r_low, errors} = '0;
    fork
      begin
        @(posedge w_clk);
        @(negedge w_clk);
        idle_armed = 1'b1;   // flops have seen one reset edge.
        repeat (2) @(posedge w_clk);
        @(negedge w_clk);
        w_reset = 1'b0;
      end
      begin
        repeat (3) @(posedge r_clk);
        @(negedge r_clk);
        r_reset = 1'b0;
      end
    join
    while (!w_awready || !w_arready || !w_wready) @(negedge w_clk);
    repeat (5) @(negedge w_clk);

    full_strb = 1'b1;   // every word gets known contents first.
    for (int base = 0; base < MEM_WORDS; base += 16) begin
      write_burst(axi_addr_t'(base * 8), BURST_INCR, 8'd15, 5'd1);
    end
    full_strb = 1'b0;

    write_burst(64'h48, BURST_INCR, 8'd0, 5'd3);
    read_burst(64'h48, BURST_INCR, 8'd0, 5'd3);

    repeat (12) begin
      addr = axi_addr_t'($urandom % 4096);   // above the depth, so indices wrap.
      len  = axi_len_t'($urandom % 16);
      id   = axi_id_t'($urandom);
      write_burst(addr, BURST_INCR, len, id);
      read_burst(addr, BURST_INCR, len, axi_id_t'($urandom));
    end

    addr = axi_addr_t'($urandom % 512);
    write_burst(addr, BURST_FIXED, 8'd7, 5'd9);
    read_burst(addr, BURST_FIXED, 8'd7, 5'd10);

    @(posedge w_clk);
    stall_on = 1'b1;
    repeat (10) begin
      addr = axi_addr_t'($urandom % 4096);
      len  = axi_len_t'($urandom % 16);
      write_burst(addr, BURST_INCR, len, axi_id_t'($urandom));
      read_burst(addr, BURST_INCR, len, axi_id_t'($urandom));
    end

    write_burst(64'h1f0, BURST_INCR, 8'd3, 5'd17);   // words 62, 63, 0, 1.
    write_burst(64'h1f0, BURST_WRAP, 8'd3, 5'd18);
    read_burst(64'h1f0, BURST_INCR, 8'd3, 5'd19);
    read_burst(64'h1f0, BURST_WRAP, 8'd3, 5'd20);

    repeat (5) @(negedge w_clk);
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter real period = 100.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

// ==== hdl/axi_cdc_mem_top.sv ====
`timescale 1ns/100ps

module axi_cdc_mem_top import axi_pkg::*; (
  input  logic       w_clk,
  input  logic       w_reset,
  input  logic       r_clk,
  input  logic       r_reset,
  input  axi_addr_t  w_awaddr, w_araddr,
  input  axi_burst_t w_awburst, w_arburst,
  input  axi_id_t    w_awid, w_arid,
  input  axi_len_t   w_awlen, w_arlen,
  input  axi_size_t  w_awsize, w_arsize,
  input  logic       w_awvalid, w_arvalid,
  output logic       w_awready, w_arready,
  input  axi_data_t  w_wdata,
  input  axi_strb_t  w_wstrb,
  input  logic       w_wlast, w_wvalid,
  output logic       w_wready,
  output axi_id_t    w_bid, w_rid,
  output axi_resp_t  w_bresp, w_rresp,
  output axi_data_t  w_rdata,
  output logic       w_bvalid, w_rvalid, w_rlast,
  input  logic       w_bready, w_rready
);

  // r_clk side channels between bridge and memory.
  axi_addr_t  r_awaddr, r_araddr;
  axi_burst_t r_awburst, r_arburst;
  axi_id_t    r_awid, r_arid, r_bid, r_rid;
  axi_len_t   r_awlen, r_arlen;
  axi_data_t  r_wdata, r_rdata;
  axi_strb_t  r_wstrb;
  axi_resp_t  r_bresp, r_rresp;
  logic       r_awvalid, r_awready, r_arvalid, r_arready;
  logic       r_wvalid, r_wready, r_wlast;
  logic       r_bvalid, r_bready, r_rvalid, r_rready, r_rlast;

  // size is carried across but the memory uses full-width beats.
  axi_async_bridge bridge0 (
    .r_awsize(),
    .r_arsize(),
    .*
  );

  axi_mem_slave mem0 (
    .clk(r_clk), .reset(r_reset),
    .awaddr(r_awaddr), .awburst(r_awburst), .awid(r_awid), .awlen(r_awlen),
    .awvalid(r_awvalid), .awready(r_awready),
    .wdata(r_wdata), .wstrb(r_wstrb), .wlast(r_wlast),
    .wvalid(r_wvalid), .wready(r_wready),
    .bid(r_bid), .bresp(r_bresp), .bvalid(r_bvalid), .bready(r_bready),
    .araddr(r_araddr), .arburst(r_arburst), .arid(r_arid), .arlen(r_arlen),
    .arvalid(r_arvalid), .arready(r_arready),
    .rid(r_rid), .rresp(r_rresp), .rdata(r_rdata), .rlast(r_rlast),
    .rvalid(r_rvalid), .rready(r_rready)
  );

endmodule

// ==== hdl/axi_mem_slave.sv ====
`timescale 1ns/100ps

module axi_mem_slave import axi_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  axi_addr_t  awaddr, araddr,
  input  axi_burst_t awburst, arburst,
  input  axi_id_t    awid, arid,
  input  axi_len_t   awlen, arlen,
  input  logic       awvalid, arvalid,
  output logic       awready, arready,
  input  axi_data_t  wdata,
  input  axi_strb_t  wstrb,
  input  logic       wlast, wvalid,
  output logic       wready,
  output axi_id_t    bid, rid,
  output axi_resp_t  bresp, rresp,
  output axi_data_t  rdata,
  output logic       bvalid, rvalid, rlast,
  input  logic       bready, rready
);

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

  axi_data_t  mem [MEM_WORDS];   // no reset, written before read.

  wr_state_t  wr_state;
  axi_id_t    wr_id;
  axi_burst_t wr_burst;
  mem_idx_t   wr_idx;

  rd_state_t  rd_state;
  axi_id_t    rd_id;
  axi_burst_t rd_burst;
  axi_len_t   rd_len;
  axi_len_t   rd_cnt;
  mem_idx_t   rd_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write sequencer
  assign awready = (wr_state == WR_IDLE);
  assign wready  = (wr_state == WR_DATA);
  assign bvalid  = (wr_state == WR_RESP);
  assign bid     = wr_id;
  assign bresp   = (wr_burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state <= WR_IDLE;
    end else begin
      case (wr_state)
        WR_IDLE: if (awvalid) wr_state <= WR_DATA;
        WR_DATA: if (wvalid && wlast) wr_state <= WR_RESP;
        default: if (bready) wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awready && awvalid) begin
      wr_id    <= awid;
      wr_burst <= awburst;
      wr_idx   <= awaddr[3 +: MEM_ADDR_BITS];   // word index, wraps at depth.
    end else if (wready && wvalid && wr_burst == BURST_INCR) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wready && wvalid && wr_burst != BURST_WRAP) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wstrb[i]) mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read sequencer
  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_DATA);
  assign rid     = rd_id;
  assign rlast   = (rd_cnt == rd_len);
  assign rresp   = (rd_burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
  assign rdata   = (rd_burst == BURST_WRAP) ? '0 : mem[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= RD_IDLE;
    end else if (rd_state == RD_IDLE) begin
      if (arvalid) rd_state <= RD_DATA;
    end else if (rready && rlast) begin
      rd_state <= RD_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (arready && arvalid) begin
      rd_id    <= arid;
      rd_burst <= arburst;
      rd_len   <= arlen;
      rd_cnt   <= '0;
      rd_idx   <= araddr[3 +: MEM_ADDR_BITS];
    end else if (rvalid && rready) begin
      rd_cnt <= rd_cnt + 1'b1;
      if (rd_burst == BURST_INCR) rd_idx <= rd_idx + 1'b1;   // fixed stays put.
    end
  end

endmodule

// ==== hdl/axi_async_bridge.sv ====
`timescale 1ns/100ps

module axi_async_bridge import axi_pkg::*; (
  input  logic       w_clk,
  input  logic       w_reset,
  input  logic       r_clk,
  input  logic       r_reset,
  // master side, w_clk domain.
  input  axi_addr_t  w_awaddr, w_araddr,
  input  axi_burst_t w_awburst, w_arburst,
  input  axi_id_t    w_awid, w_arid,
  input  axi_len_t   w_awlen, w_arlen,
  input  axi_size_t  w_awsize, w_arsize,
  input  logic       w_awvalid, w_arvalid,
  output logic       w_awready, w_arready,
  input  axi_data_t  w_wdata,
  input  axi_strb_t  w_wstrb,
  input  logic       w_wlast, w_wvalid,
  output logic       w_wready,
  output axi_id_t    w_bid, w_rid,
  output axi_resp_t  w_bresp, w_rresp,
  output axi_data_t  w_rdata,
  output logic       w_bvalid, w_rvalid, w_rlast,
  input  logic       w_bready, w_rready,
  // slave side, r_clk domain.
  output axi_addr_t  r_awaddr, r_araddr,
  output axi_burst_t r_awburst, r_arburst,
  output axi_id_t    r_awid, r_arid,
  output axi_len_t   r_awlen, r_arlen,
  output axi_size_t  r_awsize, r_arsize,
  output logic       r_awvalid, r_arvalid,
  input  logic       r_awready, r_arready,
  output axi_data_t  r_wdata,
  output axi_strb_t  r_wstrb,
  output logic       r_wlast, r_wvalid,
  input  logic       r_wready,
  input  axi_id_t    r_bid, r_rid,
  input  axi_resp_t  r_bresp, r_rresp,
  input  axi_data_t  r_rdata,
  input  logic       r_bvalid, r_rvalid, r_rlast,
  output logic       r_bready, r_rready
);

  logic [AX_BITS-1:0] aw_in;
  logic [AX_BITS-1:0] aw_out;
  logic [W_BITS-1:0]  w_in;
  logic [W_BITS-1:0]  w_out;
  logic [B_BITS-1:0]  b_in;
  logic [B_BITS-1:0]  b_out;
  logic [AX_BITS-1:0] ar_in;
  logic [AX_BITS-1:0] ar_out;
  logic [R_BITS-1:0]  r_in;
  logic [R_BITS-1:0]  r_out;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // w_clk to r_clk: AW, W, AR
  assign aw_in = {w_awaddr, w_awburst, w_awid, w_awlen, w_awsize};
  assign {r_awaddr, r_awburst, r_awid, r_awlen, r_awsize} = aw_out;

  cdc_async_fifo #(.DATA_WIDTH(AX_BITS)) aw_sync (
    .wr_clk(w_clk), .wr_reset(w_reset), .wr_valid(w_awvalid), .wr_ready(w_awready),
    .wr_data(aw_in),
    .rd_clk(r_clk), .rd_reset(r_reset), .rd_valid(r_awvalid), .rd_ready(r_awready),
    .rd_data(aw_out)
  );

  assign w_in = {w_wdata, w_wstrb, w_wlast};
  assign {r_wdata, r_wstrb, r_wlast} = w_out;

  cdc_async_fifo #(.DATA_WIDTH(W_BITS)) w_sync (
    .wr_clk(w_clk), .wr_reset(w_reset), .wr_valid(w_wvalid), .wr_ready(w_wready),
    .wr_data(w_in),
    .rd_clk(r_clk), .rd_reset(r_reset), .rd_valid(r_wvalid), .rd_ready(r_wready),
    .rd_data(w_out)
  );

  assign ar_in = {w_araddr, w_arburst, w_arid, w_arlen, w_arsize};
  assign {r_araddr, r_arburst, r_arid, r_arlen, r_arsize} = ar_out;

  cdc_async_fifo #(.DATA_WIDTH(AX_BITS)) ar_sync (
    .wr_clk(w_clk), .wr_reset(w_reset), .wr_valid(w_arvalid), .wr_ready(w_arready),
    .wr_data(ar_in),
    .rd_clk(r_clk), .rd_reset(r_reset), .rd_valid(r_arvalid), .rd_ready(r_arready),
    .rd_data(ar_out)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // r_clk to w_clk: B, R
  assign b_in = {r_bid, r_bresp};
  assign {w_bid, w_bresp} = b_out;

  cdc_async_fifo #(.DATA_WIDTH(B_BITS)) b_sync (
    .wr_clk(r_clk), .wr_reset(r_reset), .wr_valid(r_bvalid), .wr_ready(r_bready),
    .wr_data(b_in),
    .rd_clk(w_clk), .rd_reset(w_reset), .rd_valid(w_bvalid), .rd_ready(w_bready),
    .rd_data(b_out)
  );

  assign r_in = {r_rid, r_rresp, r_rdata, r_rlast};
  assign {w_rid, w_rresp, w_rdata, w_rlast} = r_out;

  cdc_async_fifo #(.DATA_WIDTH(R_BITS)) r_sync (
    .wr_clk(r_clk), .wr_reset(r_reset), .wr_valid(r_rvalid), .wr_ready(r_rready),
    .wr_data(r_in),
    .rd_clk(w_clk), .rd_reset(w_reset), .rd_valid(w_rvalid), .rd_ready(w_rready),
    .rd_data(r_out)
  );

endmodule

// ==== hdl/cdc_async_fifo.sv ====
`timescale 1ns/100ps

module cdc_async_fifo import cdc_pkg::*; #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  wr_clk,
  input  logic                  wr_reset,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_reset,
  output logic                  rd_valid,
  input  logic                  rd_ready,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] storage [FIFO_DEPTH];

  cdc_ptr_t wr_bin;
  cdc_ptr_t wr_bin_next;
  cdc_ptr_t wr_gray;
  cdc_ptr_t rd_gray_meta;   // rd pointer, first flop in wr_clk.
  cdc_ptr_t rd_gray_sync;
  logic     full;
  logic     wr_push;

  cdc_ptr_t rd_bin;
  cdc_ptr_t rd_bin_next;
  cdc_ptr_t rd_gray;
  cdc_ptr_t wr_gray_meta;   // wr pointer, first flop in rd_clk.
  cdc_ptr_t wr_gray_sync;
  logic     empty;
  logic     rd_pop;

  function automatic cdc_ptr_t bin_to_gray(input cdc_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  assign wr_bin_next = wr_bin + 1'b1;
  // full when the two top gray bits differ and the rest agree.
  assign full     = (wr_gray == {~rd_gray_sync[PTR_BITS -: 2], rd_gray_sync[PTR_BITS-2:0]});
  assign wr_ready = ~full;
  assign wr_push  = wr_valid & wr_ready;

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_push) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= bin_to_gray(wr_bin_next);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      storage[wr_bin[PTR_BITS-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  assign rd_bin_next = rd_bin + 1'b1;
  assign empty    = (rd_gray == wr_gray_sync);
  assign rd_valid = ~empty;
  assign rd_pop   = rd_valid & rd_ready;
  assign rd_data  = storage[rd_bin[PTR_BITS-1:0]];   // head entry.

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_pop) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= bin_to_gray(rd_bin_next);
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_reset) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

endmodule

// ==== hdl/cdc_pkg.sv ====
package cdc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // async FIFO geometry
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_BITS   = 3;            // index bits.

  // index plus one wrap bit, so full and empty differ.
  typedef logic [PTR_BITS:0] cdc_ptr_t;

endpackage

// ==== hdl/axi_pkg.sv ====
package axi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths and field types
  localparam int DATA_WIDTH = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  typedef logic [63:0]           axi_addr_t;
  typedef logic [4:0]            axi_id_t;
  typedef logic [7:0]            axi_len_t;   // beats minus one.
  typedef logic [2:0]            axi_size_t;
  typedef logic [1:0]            axi_burst_t;
  typedef logic [1:0]            axi_resp_t;
  typedef logic [DATA_WIDTH-1:0] axi_data_t;
  typedef logic [STRB_WIDTH-1:0] axi_strb_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol encodings
  localparam axi_burst_t BURST_FIXED = 2'b00;
  localparam axi_burst_t BURST_INCR  = 2'b01;
  localparam axi_burst_t BURST_WRAP  = 2'b10;
  localparam axi_resp_t  RESP_OKAY   = 2'b00;
  localparam axi_resp_t  RESP_SLVERR = 2'b10;

  // packed channel widths for the clock crossing
  localparam int AX_BITS = 64 + 2 + 5 + 8 + 3;
  localparam int W_BITS  = DATA_WIDTH + STRB_WIDTH + 1;
  localparam int R_BITS  = 5 + 2 + DATA_WIDTH + 1;
  localparam int B_BITS  = 5 + 2;

  localparam int MEM_WORDS     = 64;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  typedef logic [MEM_ADDR_BITS-1:0] mem_idx_t;

endpackage
